// File: source/trace_cfg.svh
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// legal instruction window, word aligned
`define PC_LOW 32'h0000_3000
`define PC_HIGH 32'h0000_4fff

// data window starts at zero
`define ADDR_HIGH 32'h0000_2fff

// highest register in the grf
`define GRF_MAX 16'd31

// fifo depths
`define CHAR_DEPTH 8
`define VERDICT_DEPTH 4

// credits granted by the verdict consumer after reset
`define OUT_CREDITS 2

`endif

// File: source/trace_pkg.sv
package trace_pkg;

    // one ascii character of the trace
    typedef logic [7:0] trace_char_t;

    // kind of trace line
    typedef enum logic [1:0] {
        fmt_none      = 2'd0,
        fmt_reg_write = 2'd1,
        fmt_mem_write = 2'd2
    } trace_format_e;

    typedef struct packed {
        trace_format_e format;
        logic [15:0]   timestamp;  // decimal field
        logic [31:0]   pc;
        logic [15:0]   grf;        // only for reg_write
        logic [31:0]   addr;       // only for mem_write
        logic [31:0]   data;
    } trace_record_t;

    typedef struct packed {
        logic grf_bad;
        logic addr_bad;
        logic pc_bad;
        logic time_bad;
    } error_code_t;

    typedef struct packed {
        trace_record_t record;
        error_code_t   errors;
    } verdict_t;

endpackage

// File: source/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             push,
    input  payload_t                         push_data,
    input  logic                             pop,
    output payload_t                         head,
    output logic                             not_empty,
    output logic [$clog2(depth + 1) - 1:0]   count
);

    localparam int count_w = $clog2(depth + 1);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t mem [depth];
    logic [ptr_w - 1:0] wr_ptr;
    logic [ptr_w - 1:0] rd_ptr;
    logic full;
    logic do_push;
    logic do_pop;

    function automatic logic [ptr_w - 1:0] next_ptr(logic [ptr_w - 1:0] p);
        if (p == ptr_w'(depth - 1)) begin
            return '0;  // depth need not be a power of two
        end
        return p + 1'b1;
    endfunction

    assign full = (count == count_w'(depth));
    assign not_empty = (count != '0);
    assign do_push = push && !full;
    assign do_pop = pop && not_empty;
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + count_w'(do_push) - count_w'(do_pop);
        end
    end

    // whoever feeds this fifo must hold a credit for every push
    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("credit_fifo: push while full");

endmodule

// File: source/trace_parser.sv
`timescale 1ns/1ps

module trace_parser (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     char_valid,
    input  trace_pkg::trace_char_t   char_data,
    input  logic                     stall,
    output logic                     char_pop,
    output logic                     rec_valid,
    output trace_pkg::trace_record_t record
);

    import trace_pkg::*;

    localparam logic [3:0] dec_digits = 4'd4;  // time and register
    localparam logic [3:0] hex_digits = 4'd8;  // pc, addr, data

    typedef enum logic [3:0] {
        st_idle,
        st_time,
        st_pc,
        st_gap1,   // after ':'
        st_grf,
        st_addr,
        st_gap2,   // before '<'
        st_eq,
        st_gap3,   // after '='
        st_data
    } state_e;

    state_e state;
    logic [3:0] cnt;
    logic dec;
    logic hex;

    function automatic logic is_dec(trace_char_t c);
        return (c >= "0") && (c <= "9");
    endfunction

    // lower case only
    function automatic logic [3:0] hex_nibble(trace_char_t c);
        return is_dec(c) ? c[3:0] : c[3:0] + 4'd9;
    endfunction

    function automatic logic [15:0] dec_acc(logic [15:0] v, trace_char_t c);
        return (v << 3) + (v << 1) + {12'd0, c[3:0]};  // v * 10 + digit
    endfunction

    assign dec = is_dec(char_data);
    assign hex = dec || ((char_data >= "a") && (char_data <= "f"));
    assign char_pop = char_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            cnt <= '0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            if (char_pop) begin
                if (char_data == "^") begin
                    state <= st_time;  // restart from anywhere
                    cnt <= '0;
                end else begin
                    // anything not matched below drops the line
                    state <= st_idle;
                    case (state)
                        st_time: begin
                            if (dec && cnt < dec_digits) begin
                                state <= st_time;
                                cnt <= cnt + 1'b1;
                            end else if (char_data == "@" && cnt != '0) begin
                                state <= st_pc;
                                cnt <= '0;
                            end
                        end
                        st_pc: begin
                            if (hex && cnt < hex_digits) begin
                                state <= st_pc;
                                cnt <= cnt + 1'b1;
                            end else if (char_data == ":" && cnt == hex_digits) begin
                                state <= st_gap1;
                            end
                        end
                        st_gap1: begin
                            cnt <= '0;
                            if (char_data == " ") state <= st_gap1;
                            else if (char_data == "$") state <= st_grf;
                            else if (char_data == "*") state <= st_addr;
                        end
                        st_grf: begin
                            if (dec && cnt < dec_digits) begin
                                state <= st_grf;
                                cnt <= cnt + 1'b1;
                            end else if (char_data == " " && cnt != '0) begin
                                state <= st_gap2;
                            end else if (char_data == "<" && cnt != '0) begin
                                state <= st_eq;
                            end
                        end
                        st_addr: begin
                            if (hex && cnt < hex_digits) begin
                                state <= st_addr;
                                cnt <= cnt + 1'b1;
                            end else if (char_data == " " && cnt == hex_digits) begin
                                state <= st_gap2;
                            end else if (char_data == "<" && cnt == hex_digits) begin
                                state <= st_eq;
                            end
                        end
                        st_gap2: begin
                            if (char_data == " ") state <= st_gap2;
                            else if (char_data == "<") state <= st_eq;
                        end
                        st_eq: begin
                            if (char_data == "=") state <= st_gap3;
                        end
                        st_gap3: begin
                            if (char_data == " ") begin
                                state <= st_gap3;
                            end else if (hex) begin
                                state <= st_data;
                                cnt <= 4'd1;
                            end
                        end
                        st_data: begin
                            if (hex && cnt < hex_digits) begin
                                state <= st_data;
                                cnt <= cnt + 1'b1;
                            end else if (char_data == "#" && cnt == hex_digits) begin
                                rec_valid <= 1'b1;  // record complete
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // stale fields of a dropped line are cleared by the next '^'
    always_ff @(posedge clk) begin
        if (char_pop) begin
            if (char_data == "^") begin
                record <= '0;
            end else begin
                case (state)
                    st_time: if (dec) record.timestamp <= dec_acc(record.timestamp, char_data);
                    st_pc: if (hex) record.pc <= {record.pc[27:0], hex_nibble(char_data)};
                    st_gap1: begin
                        if (char_data == "$") record.format <= fmt_reg_write;
                        else if (char_data == "*") record.format <= fmt_mem_write;
                    end
                    st_grf: if (dec) record.grf <= dec_acc(record.grf, char_data);
                    st_addr: if (hex) record.addr <= {record.addr[27:0], hex_nibble(char_data)};
                    st_gap3, st_data: begin
                        if (hex) record.data <= {record.data[27:0], hex_nibble(char_data)};
                    end
                    default: ;
                endcase
            end
        end
    end

    // a line is far longer than one character
    assert property (@(posedge clk) disable iff (reset) rec_valid |=> !rec_valid)
        else $error("trace_parser: back to back records");

endmodule

// File: source/record_checker.sv
`timescale 1ns/1ps
`include "trace_cfg.svh"

module record_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rec_valid,
    input  trace_pkg::trace_record_t record,
    input  logic [15:0]              freq,
    output logic                     push,
    output trace_pkg::verdict_t      verdict
);

    import trace_pkg::*;

    logic [15:0] half_freq;
    logic [15:0] time_mask;
    error_code_t errors;

    // freq is a power of two, so the mask is every bit below freq/2
    assign half_freq = freq >> 1;
    assign time_mask = half_freq - 16'd1;

    always_comb begin
        errors.time_bad = |(record.timestamp & time_mask);
        errors.pc_bad = (record.pc < `PC_LOW) || (record.pc > `PC_HIGH)
                        || (record.pc[1:0] != 2'b00);
        errors.addr_bad = (record.format == fmt_mem_write)
                          && ((record.addr > `ADDR_HIGH) || (record.addr[1:0] != 2'b00));
        errors.grf_bad = (record.format == fmt_reg_write) && (record.grf > `GRF_MAX);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= rec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rec_valid) begin
            verdict.record <= record;
            verdict.errors <= errors;
        end
    end

endmodule

// File: source/trace_checker.sv
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  trace_pkg::trace_char_t in_char,
    output logic                   in_credit,
    input  logic [15:0]            freq,
    input  logic                   out_credit,
    output logic                   out_valid,
    output trace_pkg::verdict_t    out_verdict
);

    import trace_pkg::*;

    localparam int verdict_cnt_w = $clog2(`VERDICT_DEPTH + 1);
    localparam int credit_w = $clog2(`OUT_CREDITS + 1);

    trace_char_t char_data;
    logic char_valid;
    logic char_pop;
    logic stall;
    logic rec_valid;
    trace_record_t record;
    logic ver_push;
    verdict_t ver_data;
    logic ver_not_empty;
    logic [verdict_cnt_w - 1:0] ver_count;
    logic [credit_w - 1:0] out_credits;

    credit_fifo #(.payload_t(trace_char_t), .depth(`CHAR_DEPTH)) char_fifo (
        .clk(clk), .reset(reset),
        .push(in_valid), .push_data(in_char),
        .pop(char_pop), .head(char_data),
        .not_empty(char_valid), .count()
    );

    trace_parser parser (
        .clk(clk), .reset(reset),
        .char_valid(char_valid), .char_data(char_data), .stall(stall),
        .char_pop(char_pop), .rec_valid(rec_valid), .record(record)
    );

    record_checker rec_checker (
        .clk(clk), .reset(reset),
        .rec_valid(rec_valid), .record(record), .freq(freq),
        .push(ver_push), .verdict(ver_data)
    );

    credit_fifo #(.payload_t(verdict_t), .depth(`VERDICT_DEPTH)) verdict_fifo (
        .clk(clk), .reset(reset),
        .push(ver_push), .push_data(ver_data),
        .pop(out_valid), .head(out_verdict),
        .not_empty(ver_not_empty), .count(ver_count)
    );

    // leave room for a record still in the parser or checker register
    assign stall = (ver_count == verdict_cnt_w'(`VERDICT_DEPTH))
                   || ((ver_count == verdict_cnt_w'(`VERDICT_DEPTH - 1)) && (rec_valid || ver_push));

    assign out_valid = ver_not_empty && (out_credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            in_credit <= 1'b0;
            out_credits <= credit_w'(`OUT_CREDITS);
        end else begin
            in_credit <= char_pop;  // one credit back per consumed char
            out_credits <= out_credits - credit_w'(out_valid) + credit_w'(out_credit);
        end
    end

    // consumer may only return what it was given
    assert property (@(posedge clk) disable iff (reset)
                     out_credits <= credit_w'(`OUT_CREDITS))
        else $error("trace_checker: output credits above grant");

endmodule

// File: testbench/tb_trace_checker.sv
`timescale 1ns/1ps
`include "trace_cfg.svh"

module tb_trace_checker;

    import trace_pkg::*;

    logic clk;
    logic reset;
    logic in_valid;
    trace_char_t in_char;
    logic in_credit;
    logic [15:0] freq;
    logic out_credit;
    logic out_valid;
    verdict_t out_verdict;

    string cmds[$];
    verdict_t exp_verdicts[$];
    string exp_names[$];
    verdict_t expected;
    string exp_name;
    int fd;
    int limit = 0;
    int cycle = 0;
    int sent = 0;
    int credits_back = 0;
    int held = 0;          // verdicts not yet paid back
    int stall_until = 0;
    int wait_left = 0;
    int seed = 32'h7e26818c;
    int mismatch_errs = 0;
    int other_errs = 0;
    int timeout_errs = 0;

    trace_checker uut (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_char(in_char), .in_credit(in_credit),
        .freq(freq),
        .out_credit(out_credit), .out_valid(out_valid), .out_verdict(out_verdict)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_record(input string name, input trace_record_t exp_rec,
                                input trace_record_t act_rec);
        if (act_rec !== exp_rec) begin
            $display("CHECK FAILED %s record: expected %h actual %h", name, exp_rec, act_rec);
            mismatch_errs++;
        end
    endtask

    task automatic check_errors(input string name, input error_code_t exp_err,
                                input error_code_t act_err);
        if (act_err !== exp_err) begin
            $display("CHECK FAILED %s errors: expected %b actual %b", name, exp_err, act_err);
            mismatch_errs++;
        end
    endtask

    task automatic report_and_finish();
        $display("errors: %0d value mismatches, %0d other errors, %0d timeouts",
                 mismatch_errs, other_errs, timeout_errs);
        if (mismatch_errs + other_errs + timeout_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // whole file up front so the timeout can be sized
    task automatic load_commands();
        string line;
        int chars;
        int stalls;
        chars = 0;
        stalls = 0;
        while ($fgets(line, fd) != 0) begin
            while (line.len() > 0 && (line.getc(line.len() - 1) == "\n"
                                      || line.getc(line.len() - 1) == "\r"))
                line = line.substr(0, line.len() - 2);
            if (line.len() < 2 || line.substr(0, 1) == "//") continue;
            cmds.push_back(line);
            if (line.getc(0) == "L") chars += line.len() - 2;
            if (line.getc(0) == "S") stalls++;
        end
        $fclose(fd);
        limit = 40 * chars + 200 * stalls;
    endtask

    task automatic send_line(input string text);
        for (int i = 0; i < text.len(); i++) begin
            @(negedge clk);
            while (sent - credits_back >= `CHAR_DEPTH) begin
                in_valid = 1'b0;  // out of credits
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_char = text.getc(i);
            sent++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic run_command(input string cmd);
        int value;
        string name;
        int fmt;
        int tm;
        int grf;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] err;
        verdict_t v;
        case (cmd.getc(0))
            "F": begin
                void'($sscanf(cmd, "F %d", value));
                while (exp_names.size() != 0) @(negedge clk);  // freq moves only when idle
                freq = value[15:0];
            end
            "S": begin
                void'($sscanf(cmd, "S %d", value));
                stall_until = cycle + value;
            end
            "L": send_line(cmd.substr(2, cmd.len() - 1));
            "V": begin
                void'($sscanf(cmd, "V %s %d %d %h %d %h %h %b",
                              name, fmt, tm, pc, grf, addr, data, err));
                v.record.format = trace_format_e'(fmt[1:0]);
                v.record.timestamp = tm[15:0];
                v.record.pc = pc;
                v.record.grf = grf[15:0];
                v.record.addr = addr;
                v.record.data = data;
                v.errors = err;
                exp_verdicts.push_back(v);
                exp_names.push_back(name);
            end
            default: begin
                $display("unknown command in data file: %s", cmd);
                other_errs++;
            end
        endcase
    endtask

    // credits and verdicts seen at the edge where they transfer
    always @(posedge clk) begin
        if (!reset) begin
            if (in_credit) begin
                credits_back++;
                if (credits_back > sent) begin
                    $display("in_credit returned with no character outstanding");
                    other_errs++;
                end
            end
            if (out_valid) begin
                held++;
                if (held > `OUT_CREDITS) begin
                    $display("verdict sent without an output credit, %0d unreturned", held);
                    other_errs++;
                end
                if (exp_verdicts.size() == 0) begin
                    $display("unexpected verdict %h", out_verdict);
                    other_errs++;
                end else begin
                    expected = exp_verdicts.pop_front();
                    exp_name = exp_names.pop_front();
                    check_record(exp_name, expected.record, out_verdict.record);
                    check_errors(exp_name, expected.errors, out_verdict.errors);
                end
            end
        end
    end

    // consumer returns credits after a random delay
    initial begin
        out_credit = 1'b0;
        forever begin
            @(negedge clk);
            out_credit = 1'b0;
            if (held > 0 && cycle >= stall_until) begin
                if (wait_left == 0) begin
                    out_credit = 1'b1;
                    held--;
                    wait_left = $unsigned($random(seed)) % 6;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        wait (limit != 0);
        while (cycle < limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout after %0d cycles, %0d verdicts missing, %0d of %0d credits back",
                 cycle, exp_names.size(), credits_back, sent);
        timeout_errs++;
        report_and_finish();
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_char = 8'h00;
        freq = 16'd2;
        fd = $fopen("testbench/trace_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/trace_testdata.txt");
            other_errs++;
            report_and_finish();
        end else begin
            load_commands();
            repeat (16) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            foreach (cmds[i]) run_command(cmds[i]);
            while (exp_names.size() != 0 || credits_back != sent || held != 0)
                @(negedge clk);
            repeat (20) @(negedge clk);  // room for a stray verdict
            report_and_finish();
        end
    end

endmodule

// File: verilog.f
+incdir+source
source/trace_pkg.sv
source/credit_fifo.sv
source/trace_parser.sv
source/record_checker.sv
source/trace_checker.sv
testbench/tb_trace_checker.sv

// File: Makefile
SIM = obj_dir/Vtb_trace_checker

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_trace_checker -f verilog.f

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

// File: testbench/trace_testdata.txt
// F freq | S cycles without output credits | L trace line
// V name format time pc grf addr data errors(grf addr pc time)
F 2
S 200
L ^10@00003000: $4 <= 0000abcd#
V reg_ok 1 10 00003000 4 00000000 0000abcd 0000
L ^11@00003004: *00000010 <= 12345678#
V mem_ok 2 11 00003004 0 00000010 12345678 0000
L ^12@00005000: $1 <= 00000001#
V pc_window 1 12 00005000 1 00000000 00000001 0010
L ^13@00003002: $1 <= 00000002#
V pc_align 1 13 00003002 1 00000000 00000002 0010
L ^14@00003008: *00003000 <= 00000003#
V addr_window 2 14 00003008 0 00003000 00000003 0100
L ^15@0000300c: *00000011 <= 00000004#
V addr_align 2 15 0000300c 0 00000011 00000004 0100
L ^16@00003010: $32 <= 00000005#
V grf_32 1 16 00003010 32 00000000 00000005 1000
F 4
L ^19@00003014: $2 <= 00000006#
V time_f4 1 19 00003014 2 00000000 00000006 0001
F 16
L ^12@00003018: $3 <= 00000007#
V time_f16 1 12 00003018 3 00000000 00000007 0001
L ^30 00003020: $5 <= 00000008#
L ^30@0000302: $5 <= 00000008#
L ^30@0000302C: $5 <= 00000008#
L ^30@00003020: $5 x<= 00000008#
L ^40@00003020: $5 <^48@00003024: $6 <= 00000009#
V restart 1 48 00003024 6 00000000 00000009 0000
